// ==== test/core_stim.mem ====
// First value is the record count, then one record per line
// instr pc wb_en wb_addr wb_data br_taken br_target
19
24017FFF 00400000 1 01 00007FFF 0 00000000
2402FFF0 00400004 1 02 FFFFFFF0 0 00000000
34238001 00400008 1 03 0000FFFF 0 00000000
3C041234 0040000C 1 04 12340000 0 00000000
30458F0F 00400010 1 05 00008F00 0 00000000
3846FFFF 00400014 1 06 FFFF000F 0 00000000
28470001 00400018 1 07 00000001 0 00000000
24200005 0040001C 0 00 00000000 0 00000000
00224021 00400020 1 08 00007FEF 0 00000000
01034823 00400024 1 09 FFFF7FF0 0 00000000
01265024 00400028 1 0A FFFF0000 0 00000000
01455825 0040002C 1 0B FFFF8F00 0 00000000
01646026 00400030 1 0C EDCB8F00 0 00000000
01806827 00400034 1 0D 123470FF 0 00000000
018D702A 00400038 1 0E 00000001 0 00000000
000E7900 0040003C 1 0F 00000010 0 00000000
000B8202 00400040 1 10 00FFFF8F 0 00000000
11EE0010 00400044 0 00 00000000 0 00000000
15EEFFFC 00400048 0 00 00000000 1 0040003C
10630003 0040004C 0 00 00000000 1 0040005C
14000005 00400050 0 00 00000000 0 00000000
08100040 00400054 0 00 00000000 1 00400100
0C100080 00400058 1 1F 00400060 1 00400200
03E00008 0040005C 0 00 00000000 1 00400060
03E08821 00400060 1 11 00400060 0 00000000

// ==== list.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/id_stage.sv
src/id_ex_reg.sv
src/ex_stage.sv
src/wb_stage.sv
src/mips_idex_core.sv
test/tb_mips_idex_core.sv

// ==== Makefile ====
# Verilator flow for the ID/EX pipeline slice

VERILATOR ?= verilator
TOP       ?= tb_mips_idex_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_mips_idex_core.sv ====
`timescale 1ns/1ps

module tb_mips_idex_core;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int MAX_RECORDS  = 64;
    localparam int REC_WORDS    = 7;
    localparam int RESET_CYCLES = 8;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      br_taken;
    word_t     br_target;

    // Word 0 holds the record count, seven words per record follow
    logic [31:0] stim [0:REC_WORDS*MAX_RECORDS];
    int          pend_q [$];
    int          num_records;
    int          rec;
    int          cycle_count;
    int          cycle_limit;
    int          err_count;
    int          check_count;
    logic        last_bubble;

    mips_idex_core i_mips_idex_core (
        .i_clk(clk), .i_rst_n(rst_n), .i_instr_valid(instr_valid),
        .i_instr(instr), .i_pc(pc),
        .o_wb_en(wb_en), .o_wb_addr(wb_addr), .o_wb_data(wb_data),
        .o_br_taken(br_taken), .o_br_target(br_target)
    );

    always #10 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            err_count++;
            $display("Error: %s = 0x%08h, expected 0x%08h at %0t ns",
                     name, got, expected, $time);
        end
    endtask

    // Idle and bubble cycles report nothing
    task automatic expect_quiet();
        check_val("o_wb_en", {31'd0, wb_en}, 32'd0);
        check_val("o_br_taken", {31'd0, br_taken}, 32'd0);
    endtask

    task automatic compare_record(input int idx);
        int base;
        base = 1 + REC_WORDS * idx;
        check_val("o_wb_en", {31'd0, wb_en}, stim[base + 2]);
        if (stim[base + 2][0])
        begin
            check_val("o_wb_addr", {27'd0, wb_addr}, stim[base + 3]);
            check_val("o_wb_data", wb_data, stim[base + 4]);
        end
        check_val("o_br_taken", {31'd0, br_taken}, stim[base + 5]);
        if (stim[base + 5][0])
            check_val("o_br_target", br_target, stim[base + 6]);
    endtask

    task automatic apply_record(input int idx);
        instr_valid = 1'b1;
        instr       = stim[1 + REC_WORDS * idx];
        pc          = stim[2 + REC_WORDS * idx];
    endtask

    // Garbage on the bus while the strobe is low
    task automatic insert_bubble();
        instr_valid = 1'b0;
        instr       = $urandom;
        pc          = $urandom;
    endtask

    task automatic run_records();
        int idx;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        while (rec < num_records || pend_q.size() > 0)
        begin
            // Two cycles from acceptance to result
            if (pend_q.size() == 2 || rec >= num_records)
            begin
                idx = pend_q.pop_front();
                if (idx < 0)
                    expect_quiet();
                else
                    compare_record(idx);
            end
            else
                expect_quiet();
            if (rec >= num_records)
                instr_valid = 1'b0;
            else if (!last_bubble && ($urandom % 4) == 0)
            begin
                insert_bubble();
                pend_q.push_back(-1);
                last_bubble = 1'b1;
            end
            else
            begin
                apply_record(rec);
                pend_q.push_back(rec);
                rec++;
                last_bubble = 1'b0;
            end
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        err_count   = 0;
        check_count = 0;
        cycle_count = 0;
        rec         = 0;
        last_bubble = 1'b1;
        void'($urandom(32'hd9f0));
        $readmemh("test/core_stim.mem", stim);
        num_records = int'(stim[0]);
        cycle_limit = RESET_CYCLES + 2 * num_records + 20;
        if (num_records < 1 || num_records > MAX_RECORDS)
        begin
            $display("Stimulus file is missing, empty or holds too many records");
            $display("Simulation failed");
        end
        else
        begin
            run_records();
            $display("Checks: %0d, errors: %0d", check_count, err_count);
            if (err_count == 0)
                $display("Simulation completed successfully");
            else
                $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src/mips_idex_core.sv ====
`timescale 1ns/1ps

module mips_idex_core
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_instr_valid,
    input  isa_pkg::word_t     i_instr,
    input  isa_pkg::word_t     i_pc,
    output logic               o_wb_en,
    output isa_pkg::reg_addr_t o_wb_addr,
    output isa_pkg::word_t     o_wb_data,
    output logic               o_br_taken,
    output isa_pkg::word_t     o_br_target
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // Decode outputs
    word_t     id_pc4, id_pc8, id_instr, id_rs_data, id_rt_data, id_ext_imm;
    reg_addr_t id_rs, id_rt, id_rd;
    logic      id_valid, id_jump, id_jal, id_jr, id_alu_src, id_reg_dst;
    logic      id_branch, id_nbranch, id_reg_write, id_lui;
    alu_op_t   id_alu_op;

    // ID/EX register outputs
    word_t     ie_pc4, ie_pc8, ie_instr, ie_rs_data, ie_rt_data, ie_ext_imm;
    reg_addr_t ie_rs, ie_rt, ie_rd;
    logic      ie_valid, ie_jump, ie_jal, ie_jr, ie_alu_src, ie_reg_dst;
    logic      ie_branch, ie_nbranch, ie_reg_write, ie_lui;
    alu_op_t   ie_alu_op;

    // Execute outputs
    word_t     ex_alu_result, ex_pc8, ex_target;
    reg_addr_t ex_dest;
    logic      ex_valid, ex_reg_write, ex_jal, ex_br_taken;

    id_stage i_id_stage (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_instr_valid(i_instr_valid),
        .i_instr(i_instr), .i_pc(i_pc),
        .i_wb_en(o_wb_en), .i_wb_addr(o_wb_addr), .i_wb_data(o_wb_data),
        .o_valid(id_valid), .o_pc4(id_pc4), .o_pc8(id_pc8), .o_instr(id_instr),
        .o_rs_data(id_rs_data), .o_rt_data(id_rt_data), .o_ext_imm(id_ext_imm),
        .o_rs(id_rs), .o_rt(id_rt), .o_rd(id_rd),
        .o_jump(id_jump), .o_jal(id_jal), .o_jr(id_jr), .o_alu_src(id_alu_src),
        .o_alu_op(id_alu_op), .o_reg_dst(id_reg_dst), .o_branch(id_branch),
        .o_nbranch(id_nbranch), .o_reg_write(id_reg_write), .o_lui(id_lui)
    );

    id_ex_reg i_id_ex_reg (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(id_valid),
        .i_pc4(id_pc4), .i_pc8(id_pc8), .i_instr(id_instr),
        .i_rs_data(id_rs_data), .i_rt_data(id_rt_data), .i_ext_imm(id_ext_imm),
        .i_rs(id_rs), .i_rt(id_rt), .i_rd(id_rd),
        .i_jump(id_jump), .i_jal(id_jal), .i_jr(id_jr), .i_alu_src(id_alu_src),
        .i_alu_op(id_alu_op), .i_reg_dst(id_reg_dst), .i_branch(id_branch),
        .i_nbranch(id_nbranch), .i_reg_write(id_reg_write), .i_lui(id_lui),
        .o_valid(ie_valid), .o_pc4(ie_pc4), .o_pc8(ie_pc8), .o_instr(ie_instr),
        .o_rs_data(ie_rs_data), .o_rt_data(ie_rt_data), .o_ext_imm(ie_ext_imm),
        .o_rs(ie_rs), .o_rt(ie_rt), .o_rd(ie_rd),
        .o_jump(ie_jump), .o_jal(ie_jal), .o_jr(ie_jr), .o_alu_src(ie_alu_src),
        .o_alu_op(ie_alu_op), .o_reg_dst(ie_reg_dst), .o_branch(ie_branch),
        .o_nbranch(ie_nbranch), .o_reg_write(ie_reg_write), .o_lui(ie_lui)
    );

    ex_stage i_ex_stage (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(ie_valid),
        .i_pc4(ie_pc4), .i_pc8(ie_pc8), .i_instr(ie_instr),
        .i_rs_data(ie_rs_data), .i_rt_data(ie_rt_data), .i_ext_imm(ie_ext_imm),
        .i_rs(ie_rs), .i_rt(ie_rt), .i_rd(ie_rd),
        .i_jump(ie_jump), .i_jal(ie_jal), .i_jr(ie_jr), .i_alu_src(ie_alu_src),
        .i_alu_op(ie_alu_op), .i_reg_dst(ie_reg_dst), .i_branch(ie_branch),
        .i_nbranch(ie_nbranch), .i_reg_write(ie_reg_write), .i_lui(ie_lui),
        .i_wb_en(o_wb_en), .i_wb_addr(o_wb_addr), .i_wb_data(o_wb_data),
        .o_valid(ex_valid), .o_alu_result(ex_alu_result), .o_dest(ex_dest),
        .o_reg_write(ex_reg_write), .o_jal(ex_jal), .o_pc8(ex_pc8),
        .o_br_taken(ex_br_taken), .o_target(ex_target)
    );

    wb_stage i_wb_stage (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(ex_valid),
        .i_alu_result(ex_alu_result), .i_dest(ex_dest), .i_reg_write(ex_reg_write),
        .i_jal(ex_jal), .i_pc8(ex_pc8), .i_br_taken(ex_br_taken), .i_target(ex_target),
        .o_wb_en(o_wb_en), .o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data),
        .o_br_taken(o_br_taken), .o_br_target(o_br_target)
    );

endmodule

// ==== src/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  isa_pkg::word_t     i_alu_result,
    input  isa_pkg::reg_addr_t i_dest,
    input  logic               i_reg_write,
    input  logic               i_jal,
    input  isa_pkg::word_t     i_pc8,
    input  logic               i_br_taken,
    input  isa_pkg::word_t     i_target,
    output logic               o_wb_en,
    output isa_pkg::reg_addr_t o_wb_addr,
    output isa_pkg::word_t     o_wb_data,
    output logic               o_br_taken,
    output isa_pkg::word_t     o_br_target
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic      valid_q;
    logic      reg_write_q;
    logic      br_taken_q;
    reg_addr_t dest_q;
    word_t     data_q;
    word_t     target_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            valid_q     <= 1'b0;
            reg_write_q <= 1'b0;
            br_taken_q  <= 1'b0;
        end
        else
        begin
            valid_q     <= i_valid;
            reg_write_q <= i_reg_write;
            br_taken_q  <= i_br_taken;
        end
    end

    // Link value for jal
    always_ff @(posedge i_clk)
    begin
        dest_q   <= i_dest;
        data_q   <= i_jal ? i_pc8 : i_alu_result;
        target_q <= i_target;
    end

    assign o_wb_en     = valid_q && reg_write_q && dest_q != '0;
    assign o_wb_addr   = dest_q;
    assign o_wb_data   = data_q;
    assign o_br_taken  = valid_q && br_taken_q;
    assign o_br_target = target_q;

    // Only jal both writes back and reports a jump
    a_link_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_en && o_br_taken) |-> o_wb_addr == REG_LINK);

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  isa_pkg::word_t     i_pc4,
    input  isa_pkg::word_t     i_pc8,
    input  isa_pkg::word_t     i_instr,
    input  isa_pkg::word_t     i_rs_data,
    input  isa_pkg::word_t     i_rt_data,
    input  isa_pkg::word_t     i_ext_imm,
    input  isa_pkg::reg_addr_t i_rs,
    input  isa_pkg::reg_addr_t i_rt,
    input  isa_pkg::reg_addr_t i_rd,
    input  logic               i_jump,
    input  logic               i_jal,
    input  logic               i_jr,
    input  logic               i_alu_src,
    input  pipe_pkg::alu_op_t  i_alu_op,
    input  logic               i_reg_dst,
    input  logic               i_branch,
    input  logic               i_nbranch,
    input  logic               i_reg_write,
    input  logic               i_lui,
    input  logic               i_wb_en,
    input  isa_pkg::reg_addr_t i_wb_addr,
    input  isa_pkg::word_t     i_wb_data,
    output logic               o_valid,
    output isa_pkg::word_t     o_alu_result,
    output isa_pkg::reg_addr_t o_dest,
    output logic               o_reg_write,
    output logic               o_jal,
    output isa_pkg::word_t     o_pc8,
    output logic               o_br_taken,
    output isa_pkg::word_t     o_target
);

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    shamt_t   shamt;
    alu_ctl_t alu_ctl;
    word_t    op_a;
    word_t    rt_val;
    word_t    op_b;
    logic     equal;

    assign opcode = i_instr[OP_LSB +: 6];
    assign funct  = i_instr[5:0];
    assign shamt  = i_instr[SH_LSB +: 5];

    // Forward from the instruction one ahead
    assign op_a   = (i_wb_en && i_wb_addr == i_rs && i_rs != '0) ? i_wb_data : i_rs_data;
    assign rt_val = (i_wb_en && i_wb_addr == i_rt && i_rt != '0) ? i_wb_data : i_rt_data;
    assign op_b   = i_alu_src ? i_ext_imm : rt_val;

    always_comb
    begin
        case (i_alu_op)
            ALUOP_ADD:   alu_ctl = ALU_ADD;
            ALUOP_SUB:   alu_ctl = ALU_SUB;
            ALUOP_FUNCT:
            begin
                case (funct)
                    FN_ADDU: alu_ctl = ALU_ADD;
                    FN_SUBU: alu_ctl = ALU_SUB;
                    FN_AND:  alu_ctl = ALU_AND;
                    FN_OR:   alu_ctl = ALU_OR;
                    FN_XOR:  alu_ctl = ALU_XOR;
                    FN_NOR:  alu_ctl = ALU_NOR;
                    FN_SLT:  alu_ctl = ALU_SLT;
                    FN_SLL:  alu_ctl = ALU_SLL;
                    FN_SRL:  alu_ctl = ALU_SRL;
                    default: alu_ctl = ALU_ADD;
                endcase
            end
            default:
            begin
                case (opcode)
                    OP_SLTI: alu_ctl = ALU_SLT;
                    OP_ANDI: alu_ctl = ALU_AND;
                    OP_ORI:  alu_ctl = ALU_OR;
                    OP_XORI: alu_ctl = ALU_XOR;
                    default: alu_ctl = i_lui ? ALU_LUI : ALU_ADD;
                endcase
            end
        endcase
    end

    always_comb
    begin
        case (alu_ctl)
            ALU_SUB: o_alu_result = op_a - op_b;
            ALU_AND: o_alu_result = op_a & op_b;
            ALU_OR:  o_alu_result = op_a | op_b;
            ALU_XOR: o_alu_result = op_a ^ op_b;
            ALU_NOR: o_alu_result = ~(op_a | op_b);
            ALU_SLT: o_alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLL: o_alu_result = op_b << shamt;
            ALU_SRL: o_alu_result = op_b >> shamt;
            ALU_LUI: o_alu_result = {op_b[IMM_W-1:0], {IMM_W{1'b0}}};
            default: o_alu_result = op_a + op_b;
        endcase
    end

    assign o_dest = i_reg_dst ? i_rd : (i_jal ? REG_LINK : i_rt);

    assign equal      = (op_a == rt_val);
    assign o_br_taken = i_jump | i_jr | (i_branch & equal) | (i_nbranch & ~equal);
    assign o_target   = i_jr   ? op_a
                      : i_jump ? {i_pc4[31:28], i_instr[INDEX_W-1:0], 2'b00}
                      : i_pc4 + {i_ext_imm[29:0], 2'b00};

    assign o_valid     = i_valid;
    assign o_reg_write = i_reg_write;
    assign o_jal       = i_jal;
    assign o_pc8       = i_pc8;

    // Decode never marks an instruction as both branch and jump
    a_br_jump_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> !((i_branch || i_nbranch) && (i_jump || i_jr)));

endmodule

// ==== src/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  isa_pkg::word_t     i_pc4,
    input  isa_pkg::word_t     i_pc8,
    input  isa_pkg::word_t     i_instr,
    input  isa_pkg::word_t     i_rs_data,
    input  isa_pkg::word_t     i_rt_data,
    input  isa_pkg::word_t     i_ext_imm,
    input  isa_pkg::reg_addr_t i_rs,
    input  isa_pkg::reg_addr_t i_rt,
    input  isa_pkg::reg_addr_t i_rd,
    input  logic               i_jump,
    input  logic               i_jal,
    input  logic               i_jr,
    input  logic               i_alu_src,
    input  pipe_pkg::alu_op_t  i_alu_op,
    input  logic               i_reg_dst,
    input  logic               i_branch,
    input  logic               i_nbranch,
    input  logic               i_reg_write,
    input  logic               i_lui,
    output logic               o_valid,
    output isa_pkg::word_t     o_pc4,
    output isa_pkg::word_t     o_pc8,
    output isa_pkg::word_t     o_instr,
    output isa_pkg::word_t     o_rs_data,
    output isa_pkg::word_t     o_rt_data,
    output isa_pkg::word_t     o_ext_imm,
    output isa_pkg::reg_addr_t o_rs,
    output isa_pkg::reg_addr_t o_rt,
    output isa_pkg::reg_addr_t o_rd,
    output logic               o_jump,
    output logic               o_jal,
    output logic               o_jr,
    output logic               o_alu_src,
    output pipe_pkg::alu_op_t  o_alu_op,
    output logic               o_reg_dst,
    output logic               o_branch,
    output logic               o_nbranch,
    output logic               o_reg_write,
    output logic               o_lui
);

    always_ff @(posedge i_clk)
    begin
        o_pc4     <= i_pc4;
        o_pc8     <= i_pc8;
        o_instr   <= i_instr;
        o_rs_data <= i_rs_data;
        o_rt_data <= i_rt_data;
        o_ext_imm <= i_ext_imm;
        o_rs      <= i_rs;
        o_rt      <= i_rt;
        o_rd      <= i_rd;
        o_alu_src <= i_alu_src;
        o_alu_op  <= i_alu_op;
        o_reg_dst <= i_reg_dst;
        o_lui     <= i_lui;
    end

    // A bubble loses every control that changes state
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid     <= 1'b0;
            o_jump      <= 1'b0;
            o_jal       <= 1'b0;
            o_jr        <= 1'b0;
            o_branch    <= 1'b0;
            o_nbranch   <= 1'b0;
            o_reg_write <= 1'b0;
        end
        else
        begin
            o_valid     <= i_valid;
            o_jump      <= i_valid & i_jump;
            o_jal       <= i_valid & i_jal;
            o_jr        <= i_valid & i_jr;
            o_branch    <= i_valid & i_branch;
            o_nbranch   <= i_valid & i_nbranch;
            o_reg_write <= i_valid & i_reg_write;
        end
    end

    // A jal must also take the jump path for its target
    a_jal_with_jump: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_jal |-> o_jump);

endmodule

// ==== src/id_stage.sv ====
`timescale 1ns/1ps

module id_stage
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_instr_valid,
    input  isa_pkg::word_t     i_instr,
    input  isa_pkg::word_t     i_pc,
    input  logic               i_wb_en,
    input  isa_pkg::reg_addr_t i_wb_addr,
    input  isa_pkg::word_t     i_wb_data,
    output logic               o_valid,
    output isa_pkg::word_t     o_pc4,
    output isa_pkg::word_t     o_pc8,
    output isa_pkg::word_t     o_instr,
    output isa_pkg::word_t     o_rs_data,
    output isa_pkg::word_t     o_rt_data,
    output isa_pkg::word_t     o_ext_imm,
    output isa_pkg::reg_addr_t o_rs,
    output isa_pkg::reg_addr_t o_rt,
    output isa_pkg::reg_addr_t o_rd,
    output logic               o_jump,
    output logic               o_jal,
    output logic               o_jr,
    output logic               o_alu_src,
    output pipe_pkg::alu_op_t  o_alu_op,
    output logic               o_reg_dst,
    output logic               o_branch,
    output logic               o_nbranch,
    output logic               o_reg_write,
    output logic               o_lui
);

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    zero_ext;
    word_t   regs [NUM_REGS];

    assign opcode  = i_instr[OP_LSB +: 6];
    assign funct   = i_instr[5:0];
    assign o_valid = i_instr_valid;
    assign o_instr = i_instr;
    assign o_pc4   = i_pc + 32'd4;
    assign o_pc8   = i_pc + 32'd8;
    assign o_rs    = i_instr[RS_LSB +: 5];
    assign o_rt    = i_instr[RT_LSB +: 5];
    assign o_rd    = i_instr[RD_LSB +: 5];

    // Control unit
    always_comb
    begin
        o_jump      = 1'b0;
        o_jal       = 1'b0;
        o_jr        = 1'b0;
        o_alu_src   = 1'b0;
        o_alu_op    = ALUOP_ADD;
        o_reg_dst   = 1'b0;
        o_branch    = 1'b0;
        o_nbranch   = 1'b0;
        o_reg_write = 1'b0;
        o_lui       = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                o_reg_dst   = 1'b1;
                o_alu_op    = ALUOP_FUNCT;
                o_jr        = (funct == FN_JR);
                o_reg_write = (funct != FN_JR);
            end
            OP_J:
            begin
                o_jump = 1'b1;
            end
            OP_JAL:
            begin
                o_jump      = 1'b1;
                o_jal       = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_BEQ:
            begin
                o_branch = 1'b1;
                o_alu_op = ALUOP_SUB;
            end
            OP_BNE:
            begin
                o_nbranch = 1'b1;
                o_alu_op  = ALUOP_SUB;
            end
            OP_ADDIU:
            begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                o_alu_src   = 1'b1;
                o_alu_op    = ALUOP_IMM;
                o_reg_write = 1'b1;
                o_lui       = (opcode == OP_LUI);
            end
            default:
            begin
                o_reg_write = 1'b0;
            end
        endcase
    end

    // Logic immediates are zero extended
    assign zero_ext  = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign o_ext_imm = zero_ext ? {{(32-IMM_W){1'b0}}, i_instr[IMM_W-1:0]}
                                : {{(32-IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb_en && i_wb_addr != '0)
        begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    // Write-through so a read in the writeback cycle sees the new value
    assign o_rs_data = (i_wb_en && i_wb_addr == o_rs && o_rs != '0) ? i_wb_data : regs[o_rs];
    assign o_rt_data = (i_wb_en && i_wb_addr == o_rt && o_rt != '0) ? i_wb_data : regs[o_rt];

    // Writeback never targets r0
    a_no_write_r0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_en |-> i_wb_addr != '0);

endmodule

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

    typedef logic [3:0] alu_ctl_t;

    localparam alu_ctl_t ALU_ADD = 4'd0;
    localparam alu_ctl_t ALU_SUB = 4'd1;
    localparam alu_ctl_t ALU_AND = 4'd2;
    localparam alu_ctl_t ALU_OR  = 4'd3;
    localparam alu_ctl_t ALU_XOR = 4'd4;
    localparam alu_ctl_t ALU_NOR = 4'd5;
    localparam alu_ctl_t ALU_SLT = 4'd6;
    localparam alu_ctl_t ALU_SLL = 4'd7;
    localparam alu_ctl_t ALU_SRL = 4'd8;
    localparam alu_ctl_t ALU_LUI = 4'd9;

    typedef logic [1:0] alu_op_t;

    // Add for addiu
    localparam alu_op_t ALUOP_ADD   = 2'b00;
    // Compare for beq and bne
    localparam alu_op_t ALUOP_SUB   = 2'b01;
    localparam alu_op_t ALUOP_FUNCT = 2'b10;
    // Logic immediates, slti and lui
    localparam alu_op_t ALUOP_IMM   = 2'b11;

    localparam logic [4:0] REG_LINK = 5'd31;

endpackage

// ==== src/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;

    localparam int NUM_REGS = 32;

    // Instruction field positions
    localparam int OP_LSB  = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int SH_LSB  = 6;
    localparam int IMM_W   = 16;
    localparam int INDEX_W = 26;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage
